/* csrStatus.f */
hdl/csrPkg.sv
hdl/csrReqDecode.sv
hdl/statusReg.sv
hdl/csrRespond.sv
hdl/csrStatusTop.sv
bench/csrStatusTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# build the status block testbench with Verilator, run it, judge the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module csrStatusTb -Mdir obj_dir -f csrStatus.f

# the pipe keeps a failing run from stopping the script before the search
./obj_dir/VcsrStatusTb | tee sim.log

if grep -q "Finished with no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* bench/csrStatusTb.sv */
/*
  testbench for the machine-status control block
  clock and reset, directed and random request traffic with response stalls,
  in-order reference model with expected-response queue,
  concurrent checks on every response, per-test report and cycle watchdog
*/
`timescale 1ns/100ps

module csrStatusTb;
  import csrPkg::*;

  localparam logic [11:0] mAddr      = 12'h300;
  localparam logic [11:0] sAddr      = 12'h100;
  localparam logic [11:0] badAddr    = 12'h7c0;       // no csr lives here
  localparam logic [31:0] sVisible   = 32'h800C_6122; // sd mxr sum fs spp spie sie
  localparam int          numReqs    = 34 + 200;      // directed plus random
  localparam int          cycleLimit = 4 * numReqs + 200;

  // expected response with the state it should leave behind
  typedef struct packed {
    csrRespT      resp;
    statusFieldsT status;
    privModeE     mode;
  } expT;

  logic         clk       = 1'b0;
  logic         reset     = 1'b1;
  logic         reqValid;
  csrReqT       req;
  logic         reqReady;
  logic         respValid;
  csrRespT      resp;
  logic         respReady = 1'b0;
  statusFieldsT status;
  privModeE     privMode;

  integer       seed = 32'h3b16dbc4;
  logic [31:0]  stallDraw = 32'h0;
  logic         stallOn = 1'b0;   // random respReady when set
  expT          expQ[$];
  expT          expHead;          // queue head registered for the checks
  logic         expAvail = 1'b0;
  int           inFlight = 0;     // requests accepted and not yet answered
  statusFieldsT refStatus;        // model state
  logic [1:0]   refFs;
  privModeE     refMode;
  int           reqCount = 0;
  int           respCount = 0;
  int           errors = 0;
  int           failedResps = 0;
  int           testBase = 0;
  int           cycles = 0;
  time          failTime = 0;

  always #5 clk = ~clk; // 10 ns period

  csrStatusTop dut_i (
    .clk       (clk),
    .reset     (reset),
    .reqValid  (reqValid),
    .req       (req),
    .reqReady  (reqReady),
    .respValid (respValid),
    .resp      (resp),
    .respReady (respReady),
    .status    (status),
    .privMode  (privMode)
  );

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic logic [31:0] mstatusView();
    return {refFs == 2'b11, 8'h00, refStatus.tsr, refStatus.tw, refStatus.tvm,
            refStatus.mxr, refStatus.sum, refStatus.mprv, 2'b00, refFs, refStatus.mpp,
            2'b00, refStatus.spp, refStatus.mpie, 1'b0, refStatus.spie,
            1'b0, refStatus.mie, 1'b0, refStatus.sie, 1'b0};
  endfunction

  task automatic modelStep(input csrReqT r, output expT e);
    logic        isM;
    logic        isS;
    logic        bad;
    logic        isEvent;
    logic [31:0] oldV;
    logic [31:0] newV;
    privModeE    target;
    isM     = (r.addr == mAddr);
    isS     = (r.addr == sAddr);
    isEvent = r.op inside {opTrap, opMret, opSret, opFpWrite};
    case (r.op)
      opCsrRw, opCsrRs, opCsrRc:
        bad = !(isM || isS) || (isM && refMode != machMode) || (isS && refMode == userMode);
      opMret:  bad = (refMode != machMode);
      opSret:  bad = (refMode == userMode) || (refMode == superMode && refStatus.tsr);
      default: bad = 1'b0; // traps and fp writes always go
    endcase
    oldV = isS ? (mstatusView() & sVisible) : mstatusView();
    if (!bad) begin
      case (r.op)
        opCsrRw, opCsrRs, opCsrRc: begin
          newV = (r.op == opCsrRs) ? (oldV | r.operand) :
                 (r.op == opCsrRc) ? (oldV & ~r.operand) : r.operand;
          refStatus.sie  = newV[1];  // S subset in both views
          refStatus.spie = newV[5];
          refStatus.spp  = newV[8];
          refStatus.sum  = newV[18];
          refStatus.mxr  = newV[19];
          refFs          = newV[14:13];
          if (!isS) begin
            refStatus.mie  = newV[3];
            refStatus.mpie = newV[7];
            refStatus.mpp  = (newV[12:11] == 2'b10) ? 2'b11 : newV[12:11]; // WARL
            refStatus.mprv = newV[17];
            refStatus.tvm  = newV[20];
            refStatus.tw   = newV[21];
            refStatus.tsr  = newV[22];
          end
        end
        opTrap: begin
          target = (r.trapToSuper && refMode != machMode) ? superMode : machMode;
          if (target == machMode) begin
            refStatus.mpie = refStatus.mie;
            refStatus.mie  = 1'b0;
            refStatus.mpp  = refMode;
          end else begin
            refStatus.spie = refStatus.sie;
            refStatus.sie  = 1'b0;
            refStatus.spp  = (refMode == superMode);
          end
          refMode = target;
        end
        opMret: begin
          refMode        = privModeE'(refStatus.mpp);
          refStatus.mie  = refStatus.mpie;
          refStatus.mpie = 1'b1;
          refStatus.mpp  = userMode;
          if (refMode != machMode) refStatus.mprv = 1'b0;
        end
        opSret: begin
          refMode        = refStatus.spp ? superMode : userMode;
          refStatus.sie  = refStatus.spie;
          refStatus.spie = 1'b1;
          refStatus.spp  = 1'b0;
          refStatus.mprv = 1'b0;
        end
        default: refFs = 2'b11; // fp write marks dirty
      endcase
    end
    e.resp.readData = (bad || isEvent) ? 32'h0 : oldV;
    e.resp.illegal  = bad;
    e.resp.privMode = refMode;
    e.resp.wasEvent = isEvent;
    e.status        = refStatus;
    e.mode          = refMode;
  endtask

  // per edge bookkeeping pops on a response and models and pushes on a request
  always @(posedge clk) begin
    expT e;
    if (reset) begin
      refStatus = '0;
      refFs     = 2'b00;
      refMode   = machMode;
    end else begin
      if (respValid && respReady) begin
        if (expQ.size() != 0) void'(expQ.pop_front());
        respCount++;
      end
      if (reqValid && reqReady) begin
        modelStep(req, e);
        expQ.push_back(e);
        reqCount++;
      end
    end
    expAvail <= (expQ.size() != 0);
    expHead  <= (expQ.size() != 0) ? expQ[0] : '0;
    inFlight <= expQ.size();
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic noteError();
    errors++;
    if (failTime != $time) begin // one bad response per edge at most
      failedResps++;
      failTime = $time;
    end
  endtask

  respValueA: assert property (@(posedge clk) disable iff (reset)
    respValid && respReady && expAvail |-> resp == expHead.resp)
    else begin
      $display("ERROR %0t resp expected %h actual %h", $time,
               $sampled(expHead.resp), $sampled(resp));
      noteError();
    end

  statusValueA: assert property (@(posedge clk) disable iff (reset)
    respValid && respReady && expAvail |-> status == expHead.status)
    else begin
      $display("ERROR %0t status expected %h actual %h", $time,
               $sampled(expHead.status), $sampled(status));
      noteError();
    end

  modeValueA: assert property (@(posedge clk) disable iff (reset)
    respValid && respReady && expAvail |-> privMode == expHead.mode)
    else begin
      $display("ERROR %0t privMode expected %h actual %h", $time,
               $sampled(expHead.mode), $sampled(privMode));
      noteError();
    end

  // two in flight means both stages are full, so only a draining response frees room
  reqReadyA: assert property (@(posedge clk) disable iff (reset)
    reqReady == (inFlight < 2 || respReady))
    else begin
      $display("ERROR %0t reqReady expected %b actual %b", $time,
               $sampled(inFlight < 2 || respReady), $sampled(reqReady));
      noteError();
    end

  orphanRespA: assert property (@(posedge clk) disable iff (reset)
    respValid |-> expAvail)
    else begin
      $display("a response showed up at %0t with no request outstanding", $time);
      noteError();
    end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // next stall decision
  always @(negedge clk) begin
    stallDraw = $random(seed);
  end

  always @(posedge clk) begin
    if (reset) respReady <= 1'b0;
    else       respReady <= !stallOn || (stallDraw[1:0] != 2'b00); // stall a quarter
  end

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("run stopped, still busy after %0d cycles", cycleLimit);
      $display("Finished with errors");
      $finish;
    end
  end

  // starts on a rising edge and returns on the handshake edge
  task automatic sendReq(input csrOpE op, input logic [11:0] addr,
                         input logic [31:0] operand, input logic toSuper);
    reqValid <= 1'b1;
    req      <= '{op: op, addr: addr, operand: operand, trapToSuper: toSuper};
    @(negedge clk);
    while (!reqReady) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic endTest(input string name);
    reqValid <= 1'b0;
    @(negedge clk);
    while (expQ.size() != 0 || respValid) @(negedge clk); // all answered
    @(posedge clk);
    $display("test %-12s done, %0d error(s)", name, errors - testBase);
    testBase = errors;
  endtask

  task automatic randomTraffic(input int count);
    logic [31:0] rnd;
    logic [2:0]  opSel;
    logic [11:0] addr;
    repeat (count) begin
      rnd   = $random(seed);
      opSel = (rnd[2:0] == 3'd7) ? 3'd0 : rnd[2:0];
      addr  = (rnd[5:3] == 3'd7) ? badAddr : (rnd[3] ? sAddr : mAddr);
      sendReq(csrOpE'(opSel), addr, $random(seed), rnd[6]);
    end
  endtask

  initial begin
    reqValid = 1'b0;
    req      = '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    sendReq(opCsrRs, mAddr, 32'h0, 1'b0); // plain read out of reset
    endTest("reset");

    sendReq(opCsrRw, mAddr, 32'hFFFF_FFFF, 1'b0);
    sendReq(opCsrRs, mAddr, 32'h0, 1'b0);
    sendReq(opCsrRc, mAddr, 32'h0000_1800, 1'b0);
    sendReq(opCsrRw, mAddr, 32'h0000_1000, 1'b0); // mpp 10 is reserved
    sendReq(opCsrRs, mAddr, 32'h0, 1'b0);
    sendReq(opCsrRs, badAddr, 32'h0, 1'b0);
    sendReq(opCsrRc, mAddr, 32'hFFFF_FFFF, 1'b0);
    endTest("rmw-warl");

    sendReq(opCsrRw, sAddr, 32'hFFFF_FFFF, 1'b0);
    sendReq(opCsrRs, mAddr, 32'h0, 1'b0);
    sendReq(opCsrRs, mAddr, 32'h0000_0088, 1'b0); // mie and mpie are M only
    sendReq(opCsrRs, sAddr, 32'h0, 1'b0);
    sendReq(opCsrRc, mAddr, 32'hFFFF_FFFF, 1'b0);
    endTest("sstatus");

    sendReq(opCsrRs, mAddr, 32'h0002_0008, 1'b0); // mie and mprv
    sendReq(opTrap, 12'h0, 32'h0, 1'b0);
    sendReq(opCsrRc, mAddr, 32'h0000_1800, 1'b0); // mpp to user
    sendReq(opMret, 12'h0, 32'h0, 1'b0);
    sendReq(opCsrRs, mAddr, 32'hFFFF_FFFF, 1'b0); // refused in user
    sendReq(opSret, 12'h0, 32'h0, 1'b0);
    sendReq(opTrap, 12'h0, 32'h0, 1'b1);
    sendReq(opTrap, 12'h0, 32'h0, 1'b1);
    sendReq(opMret, 12'h0, 32'h0, 1'b0);
    sendReq(opTrap, 12'h0, 32'h0, 1'b0);
    sendReq(opCsrRs, mAddr, 32'h0040_0000, 1'b0); // tsr
    sendReq(opMret, 12'h0, 32'h0, 1'b0);
    sendReq(opSret, 12'h0, 32'h0, 1'b0);
    sendReq(opTrap, 12'h0, 32'h0, 1'b0);
    sendReq(opCsrRc, mAddr, 32'h0040_0000, 1'b0);
    sendReq(opMret, 12'h0, 32'h0, 1'b0);
    sendReq(opSret, 12'h0, 32'h0, 1'b0);
    sendReq(opTrap, 12'h0, 32'h0, 1'b0);
    endTest("stacking");

    sendReq(opFpWrite, 12'h0, 32'h0, 1'b0);
    sendReq(opCsrRs, mAddr, 32'h0, 1'b0);
    sendReq(opCsrRs, sAddr, 32'h0, 1'b0);
    endTest("fp-dirty");

    stallOn <= 1'b1;
    randomTraffic(200);
    endTest("backpressure");

    countsA: assert (reqCount == respCount && expQ.size() == 0)
      else begin
        $display("responses lost or repeated, %0d requests but %0d responses",
                 reqCount, respCount);
        noteError();
      end
    $display("%0d responses, %0d passed, %0d errors", respCount,
             respCount - failedResps, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* hdl/csrStatusTop.sv */
/*
  machine-status control block, top level
  request decoder, status register and responder in a
  two-stage valid/ready pipeline
*/
`timescale 1ns/100ps

module csrStatusTop (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 reqValid,
  input  csrPkg::csrReqT       req,
  output logic                 reqReady,
  output logic                 respValid,
  output csrPkg::csrRespT      resp,
  input  logic                 respReady,
  output csrPkg::statusFieldsT status,   // live fields for the core
  output csrPkg::privModeE     privMode
);
  import csrPkg::*;

  logic            cmdValid;
  logic            cmdReady;
  statusCmdT       cmd;
  logic            cmdFire;  // decoder to responder transfer
  logic [xlen-1:0] readOld;
  privModeE        curMode;

  assign cmdFire = cmdValid & cmdReady;

  csrReqDecode decode_i (
    .clk      (clk),
    .reset    (reset),
    .reqValid (reqValid),
    .req      (req),
    .reqReady (reqReady),
    .cmdValid (cmdValid),
    .cmd      (cmd),
    .cmdReady (cmdReady),
    .privMode (privMode),
    .tsr      (status.tsr)
  );

  statusReg status_i (
    .clk      (clk),
    .reset    (reset),
    .apply    (cmdFire),
    .cmd      (cmd),
    .readOld  (readOld),
    .curMode  (curMode),
    .privMode (privMode),
    .status   (status)
  );

  csrRespond respond_i (
    .clk       (clk),
    .reset     (reset),
    .cmdValid  (cmdValid),
    .cmd       (cmd),
    .readOld   (readOld),
    .curMode   (curMode),
    .cmdReady  (cmdReady),
    .respValid (respValid),
    .respReady (respReady),
    .resp      (resp)
  );

endmodule

/* hdl/csrRespond.sv */
/*
  response output stage
  one-entry response register with valid/ready back-pressure,
  masks read data for events and illegal accesses
*/
`timescale 1ns/100ps

module csrRespond (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cmdValid,
  input  csrPkg::statusCmdT       cmd,
  input  logic [csrPkg::xlen-1:0] readOld,
  input  csrPkg::privModeE        curMode,
  output logic                    cmdReady,
  output logic                    respValid,
  input  logic                    respReady,
  output csrPkg::csrRespT         resp
);
  import csrPkg::*;

  logic fire;    // command taken this cycle
  logic isEvent; // trap, return or fp write

  // free slot, or the held response is leaving
  assign cmdReady = ~respValid | respReady;
  assign fire     = cmdValid & cmdReady;
  assign isEvent  = cmd.op inside {opTrap, opMret, opSret, opFpWrite};

  always_ff @(posedge clk) begin
    if (reset) begin
      respValid <= 1'b0;
    end else if (fire) begin
      respValid <= 1'b1;
    end else if (respReady) begin
      respValid <= 1'b0; // drained with nothing behind it
    end
  end

  // payload only, held while stalled
  always_ff @(posedge clk) begin
    if (fire) begin
      // no state leaks through a refused access
      resp.readData <= (isEvent || cmd.illegal) ? '0 : readOld;
      resp.illegal  <= cmd.illegal;
      resp.privMode <= curMode;
      resp.wasEvent <= isEvent;
    end
  end

  respStableA: assert property (@(posedge clk) disable iff (reset)
    respValid && !respReady |=> respValid && $stable(resp))
    else $error("response changed while stalled");

endmodule

/* hdl/statusReg.sv */
/*
  mstatus / sstatus state
  field registers, read views, read-modify-write with WARL
  legalization, trap and return stacking, privilege mode register
*/
`timescale 1ns/100ps

module statusReg (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    apply,    // command fires this cycle
  input  csrPkg::statusCmdT       cmd,
  output logic [csrPkg::xlen-1:0] readOld,  // addressed view before update
  output csrPkg::privModeE        curMode,  // mode after update
  output csrPkg::privModeE        privMode, // registered mode
  output csrPkg::statusFieldsT    status
);
  import csrPkg::*;

  statusFieldsT    fieldsQ, fieldsD;
  logic [1:0]      fsQ, fsD;      // fp state, 11 is dirty
  privModeE        modeQ, modeD;
  privModeE        trapTarget;
  logic            sd;
  logic            update;
  logic [xlen-1:0] mView;         // full mstatus image
  logic [xlen-1:0] sView;         // restricted sstatus image
  logic [xlen-1:0] oldView;
  logic [xlen-1:0] newVal;        // rmw result before masking
  logic [xlen-1:0] wrMask;
  logic [xlen-1:0] merged;        // masked write into mstatus image

  //////////////////////////////
  // read views
  //////////////////////////////

  assign sd = (fsQ == 2'b11); // xs is hardwired off

  assign mView = {sd, 8'b0,
                  fieldsQ.tsr, fieldsQ.tw, fieldsQ.tvm,
                  fieldsQ.mxr, fieldsQ.sum, fieldsQ.mprv,
                  2'b00, fsQ, fieldsQ.mpp, 2'b00,
                  fieldsQ.spp, fieldsQ.mpie, 1'b0, fieldsQ.spie,
                  1'b0, fieldsQ.mie, 1'b0, fieldsQ.sie, 1'b0};

  assign sView   = mView & (sstatusMask | sdBit); // hide m-only fields
  assign oldView = cmd.isSstatus ? sView : mView;
  assign readOld = oldView;

  //////////////////////////////
  // read-modify-write
  //////////////////////////////

  always_comb begin
    case (cmd.op)
      opCsrRs: newVal = oldView | cmd.operand;
      opCsrRc: newVal = oldView & ~cmd.operand;
      default: newVal = cmd.operand; // plain replace
    endcase
  end

  // sstatus writes can only reach the S subset
  assign wrMask = cmd.isSstatus ? sstatusMask : mstatusMask;
  assign merged = (mView & ~wrMask) | (newVal & wrMask);

  //////////////////////////////
  // next state
  //////////////////////////////

  // a trap from machine mode always stays in machine mode
  assign trapTarget = (cmd.trapToSuper && modeQ != machMode) ? superMode : machMode;

  always_comb begin
    fieldsD = fieldsQ;
    fsD     = fsQ;
    modeD   = modeQ;
    case (cmd.op)
      opCsrRw, opCsrRs, opCsrRc: begin
        fieldsD.tsr  = merged[22];
        fieldsD.tw   = merged[21];
        fieldsD.tvm  = merged[20];
        fieldsD.mxr  = merged[19];
        fieldsD.sum  = merged[18];
        fieldsD.mprv = merged[17];
        fsD          = merged[14:13];
        // WARL: reserved mpp reads back as machine
        fieldsD.mpp  = (merged[12:11] == 2'b10) ? machMode : merged[12:11];
        fieldsD.spp  = merged[8];
        fieldsD.mpie = merged[7];
        fieldsD.spie = merged[5];
        fieldsD.mie  = merged[3];
        fieldsD.sie  = merged[1];
      end
      opTrap: begin
        if (trapTarget == machMode) begin
          fieldsD.mpie = fieldsQ.mie;
          fieldsD.mie  = 1'b0;
          fieldsD.mpp  = modeQ;     // previous mode
        end else begin
          fieldsD.spie = fieldsQ.sie;
          fieldsD.sie  = 1'b0;
          fieldsD.spp  = modeQ[0];  // user or supervisor
        end
        modeD = trapTarget;
      end
      opMret: begin
        fieldsD.mie  = fieldsQ.mpie; // restore enable
        fieldsD.mpie = 1'b1;
        fieldsD.mpp  = userMode;     // lowest supported mode
        fieldsD.mprv = fieldsQ.mprv & (fieldsQ.mpp == machMode);
        modeD        = privModeE'(fieldsQ.mpp);
      end
      opSret: begin
        fieldsD.sie  = fieldsQ.spie;
        fieldsD.spie = 1'b1;
        fieldsD.spp  = 1'b0;
        fieldsD.mprv = 1'b0;         // sret never returns to machine mode
        modeD        = fieldsQ.spp ? superMode : userMode;
      end
      opFpWrite: fsD = 2'b11; // mark dirty
      default: ;
    endcase
  end

  assign update = apply & ~cmd.illegal; // illegal requests change nothing

  always_ff @(posedge clk) begin
    if (reset) begin
      fieldsQ <= '0;
      fsQ     <= 2'b00;
      modeQ   <= machMode; // come out of reset in machine mode
    end else if (update) begin
      fieldsQ <= fieldsD;
      fsQ     <= fsD;
      modeQ   <= modeD;
    end
  end

  assign curMode  = update ? modeD : modeQ; // seen by the responder at the fire edge
  assign privMode = modeQ;
  assign status   = fieldsQ;

  //////////////////////////////
  // checks
  //////////////////////////////

  mppLegalA: assert property (@(posedge clk) disable iff (reset)
    fieldsQ.mpp != 2'b10)
    else $error("mpp holds the reserved encoding 10");

  // returns take their mode from mpp/spp, so a bad stack would show up here
  modeLegalA: assert property (@(posedge clk) disable iff (reset)
    update |=> modeQ != 2'b10)
    else $error("privilege mode became the reserved encoding 10");

endmodule

/* hdl/csrReqDecode.sv */
/*
  request input stage
  one-entry request register with valid/ready handshake,
  csr address decode, privilege legality check as the command leaves
*/
`timescale 1ns/100ps

module csrReqDecode (
  input  logic              clk,
  input  logic              reset,
  input  logic              reqValid,
  input  csrPkg::csrReqT    req,
  output logic              reqReady,
  output logic              cmdValid,
  output csrPkg::statusCmdT cmd,
  input  logic              cmdReady,
  input  csrPkg::privModeE  privMode,  // current mode from statusReg
  input  logic              tsr        // trap sret, from the status fields
);
  import csrPkg::*;

  csrReqT reqQ;      // held request, payload only
  logic   holdQ;     // register occupied
  logic   isMstatus;
  logic   isSstatus;
  logic   illegal;

  //////////////////////////////
  // request register
  //////////////////////////////

  // accept when empty or when the held entry leaves this cycle
  assign reqReady = ~holdQ | cmdReady;
  assign cmdValid = holdQ;

  always_ff @(posedge clk) begin
    if (reset) begin
      holdQ <= 1'b0;
    end else if (reqReady) begin
      holdQ <= reqValid; // refill or drain
    end
  end

  always_ff @(posedge clk) begin
    if (reqValid && reqReady) begin
      reqQ <= req;
    end
  end

  //////////////////////////////
  // decode and legality
  //////////////////////////////

  assign isMstatus = (reqQ.addr == addrMstatus);
  assign isSstatus = (reqQ.addr == addrSstatus);

  // evaluated on the live mode, so an event ahead of this request
  // has already moved privMode by the time this one fires
  always_comb begin
    illegal = 1'b0;
    case (reqQ.op)
      opCsrRw, opCsrRs, opCsrRc: begin
        if (!isMstatus && !isSstatus) begin
          illegal = 1'b1; // no such csr here
        end else if (isMstatus && privMode != machMode) begin
          illegal = 1'b1; // m-level csr below machine mode
        end else if (isSstatus && privMode == userMode) begin
          illegal = 1'b1;
        end
      end
      opMret:    illegal = (privMode != machMode);
      opSret:    illegal = (privMode == userMode) || (privMode == superMode && tsr);
      opTrap:    illegal = 1'b0; // traps are always taken
      opFpWrite: illegal = 1'b0;
      default:   illegal = 1'b1; // unused opcode
    endcase
  end

  assign cmd.op          = reqQ.op;
  assign cmd.isSstatus   = isSstatus;
  assign cmd.illegal     = illegal;
  assign cmd.operand     = reqQ.operand;
  assign cmd.trapToSuper = reqQ.trapToSuper;

  //////////////////////////////
  // checks
  //////////////////////////////

  // privMode and tsr only move on a fire, so a stalled command,
  // illegal flag included, must stay put until the responder takes it
  cmdStableA: assert property (@(posedge clk) disable iff (reset)
    cmdValid && !cmdReady |=> cmdValid && $stable(cmd))
    else $error("command changed while stalled");

endmodule

/* hdl/csrPkg.sv */
/*
  shared definitions for the machine-status control block
  data width, privilege mode and opcode enums, CSR addresses,
  writable-field masks, request / command / response structs
  and the status fields exported to the core
*/
package csrPkg;

  localparam int xlen = 32; // fixed RV32

  // privilege modes, 2'b10 is reserved
  typedef enum logic [1:0] {
    userMode  = 2'b00,
    superMode = 2'b01,
    machMode  = 2'b11
  } privModeE;

  // request opcodes, csr accesses first, then core events
  typedef enum logic [2:0] {
    opCsrRw   = 3'd0, // read-write
    opCsrRs   = 3'd1, // read-set
    opCsrRc   = 3'd2, // read-clear
    opTrap    = 3'd3, // trap entry
    opMret    = 3'd4,
    opSret    = 3'd5,
    opFpWrite = 3'd6  // fp register file written
  } csrOpE;

  localparam logic [11:0] addrMstatus = 12'h300;
  localparam logic [11:0] addrSstatus = 12'h100;

  // writable bits of each view
  // mstatus: tsr tw tvm mxr sum mprv fs mpp spp mpie spie mie sie
  localparam logic [xlen-1:0] mstatusMask = 32'h007E_79AA;
  // sstatus: mxr sum fs spp spie sie
  localparam logic [xlen-1:0] sstatusMask = 32'h000C_6122;
  localparam logic [xlen-1:0] sdBit       = 32'h8000_0000; // read-only summary dirty

  typedef struct packed {
    csrOpE           op;
    logic [11:0]     addr;
    logic [xlen-1:0] operand;     // write data for csr ops
    logic            trapToSuper; // trap wants supervisor mode
  } csrReqT;

  typedef struct packed {
    csrOpE           op;
    logic            isSstatus;
    logic            illegal;
    logic [xlen-1:0] operand;
    logic            trapToSuper;
  } statusCmdT;

  typedef struct packed {
    logic [xlen-1:0] readData; // old view, zero for events and illegal accesses
    logic            illegal;
    privModeE        privMode; // mode after the request
    logic            wasEvent;
  } csrRespT;

  typedef struct packed {
    logic       mie;
    logic       sie;
    logic       mpie;
    logic       spie;
    logic [1:0] mpp;
    logic       spp;
    logic       mprv;
    logic       sum;
    logic       mxr;
    logic       tvm; // stored only
    logic       tw;
    logic       tsr;
  } statusFieldsT;

endpackage
